/* design/host_adapter_top.sv */
// Host stream adapter top
`timescale 1ns/10ps

module host_adapter_top (
    input  logic                              clock,
    input  logic                              reset_i,
    input  logic [link_pkg::WORD_BITS-1:0]    data_i,
    input  logic                              valid_i,
    input  logic                              downstream_stall_i,
    output logic [link_pkg::WORD_BITS-1:0]    data_o,
    output logic                              valid_o,
    output logic                              upstream_stall_o
);

    logic core_reset;
    logic gather_stall;

    logic [link_pkg::VALUE_BITS-1:0] row [link_pkg::ROW_PIXELS];
    logic row_valid;
    logic row_stall;

    logic [link_pkg::VALUE_BITS-1:0] pooled [link_pkg::ROW_OUTPUTS];
    logic pooled_valid;
    logic pooled_stall;

    logic [link_pkg::WORD_BITS-1:0] word;
    logic word_valid;
    logic word_stall;

    // Bit 31 on a valid word clears everything at the next edge
    assign core_reset = reset_i || (valid_i && data_i[link_pkg::SOFT_RESET_BIT]);
    assign upstream_stall_o = gather_stall && !core_reset;

    row_gather i_row_gather (
        .clock            (clock),
        .reset_i          (core_reset),
        .data_i           (data_i),
        .valid_i          (valid_i),
        .row_stall_i      (row_stall),
        .row_o            (row),
        .row_valid_o      (row_valid),
        .upstream_stall_o (gather_stall)
    );

    row_maxpool i_row_maxpool (
        .clock          (clock),
        .reset_i        (core_reset),
        .row_i          (row),
        .row_valid_i    (row_valid),
        .pooled_stall_i (pooled_stall),
        .row_stall_o    (row_stall),
        .pooled_o       (pooled),
        .pooled_valid_o (pooled_valid)
    );

    score_serializer i_score_serializer (
        .clock          (clock),
        .reset_i        (core_reset),
        .pooled_i       (pooled),
        .pooled_valid_i (pooled_valid),
        .word_stall_i   (word_stall),
        .pooled_stall_o (pooled_stall),
        .word_o         (word),
        .word_valid_o   (word_valid)
    );

    skid_register i_skid_register (
        .clock              (clock),
        .reset_i            (core_reset),
        .word_i             (word),
        .word_valid_i       (word_valid),
        .downstream_stall_i (downstream_stall_i),
        .word_stall_o       (word_stall),
        .word_o             (data_o),
        .word_valid_o       (valid_o)
    );

endmodule

/* design/link_pkg.sv */
// Host link definitions
package link_pkg;

    // Host word layout
    localparam int WORD_BITS = 32;
    localparam int VALUE_BITS = 8;
    localparam int SOFT_RESET_BIT = 31;

    // Row geometry seen by the host
    localparam int ROW_PIXELS = 28;
    localparam int ROW_OUTPUTS = 10;

    localparam int PIXEL_IDX_BITS = $clog2(ROW_PIXELS);
    localparam int OUTPUT_IDX_BITS = $clog2(ROW_OUTPUTS);

    // Last index of a row and of a pooled result set
    localparam logic [PIXEL_IDX_BITS-1:0] LAST_PIXEL = PIXEL_IDX_BITS'(ROW_PIXELS - 1);
    localparam logic [OUTPUT_IDX_BITS-1:0] LAST_OUTPUT = OUTPUT_IDX_BITS'(ROW_OUTPUTS - 1);

    // Buffer state of the gatherer and the serializer
    typedef enum logic {
        STREAM_FILL,
        STREAM_HOLD
    } stream_state_e;

endpackage

/* design/pool_pkg.sv */
// Pooling core definitions
package pool_pkg;

    // Window geometry along the row
    localparam int POOL_WINDOW = 4;
    localparam int POOL_STRIDE = 3;

    // Result register state
    typedef enum logic {
        POOL_EMPTY,
        POOL_FULL
    } pool_state_e;

endpackage

/* design/row_gather.sv */
// Pixel row gatherer
`timescale 1ns/10ps

module row_gather (
    input  logic                              clock,
    input  logic                              reset_i,
    input  logic [link_pkg::WORD_BITS-1:0]    data_i,
    input  logic                              valid_i,
    input  logic                              row_stall_i,
    output logic [link_pkg::VALUE_BITS-1:0]   row_o [link_pkg::ROW_PIXELS],
    output logic                              row_valid_o,
    output logic                              upstream_stall_o
);

    link_pkg::stream_state_e state;
    logic [link_pkg::PIXEL_IDX_BITS-1:0] pixel_idx;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            state <= link_pkg::STREAM_FILL;
            pixel_idx <= '0;
        end else if (state == link_pkg::STREAM_FILL) begin
            if (valid_i) begin
                if (pixel_idx == link_pkg::LAST_PIXEL) begin
                    pixel_idx <= '0;
                    state <= link_pkg::STREAM_HOLD;
                end else begin
                    pixel_idx <= pixel_idx + 1'b1;
                end
            end
        end else if (!row_stall_i) begin
            // Row taken by the pooling core
            state <= link_pkg::STREAM_FILL;
        end
    end

    // Pixel storage
    always_ff @(posedge clock) begin
        if (!reset_i && valid_i && state == link_pkg::STREAM_FILL) begin
            row_o[pixel_idx] <= data_i[link_pkg::VALUE_BITS-1:0];
        end
    end

    assign row_valid_o = (state == link_pkg::STREAM_HOLD);
    assign upstream_stall_o = (state == link_pkg::STREAM_HOLD);

endmodule

/* design/row_maxpool.sv */
// Row max-pooling core
`timescale 1ns/10ps

module row_maxpool (
    input  logic                              clock,
    input  logic                              reset_i,
    input  logic [link_pkg::VALUE_BITS-1:0]   row_i [link_pkg::ROW_PIXELS],
    input  logic                              row_valid_i,
    input  logic                              pooled_stall_i,
    output logic                              row_stall_o,
    output logic [link_pkg::VALUE_BITS-1:0]   pooled_o [link_pkg::ROW_OUTPUTS],
    output logic                              pooled_valid_o
);

    pool_pkg::pool_state_e state;
    logic [link_pkg::VALUE_BITS-1:0] window_max [link_pkg::ROW_OUTPUTS];
    logic take_row;

    // Window maxima, last window clipped at the row end
    always_comb begin
        int base;
        int pick;
        for (int k = 0; k < link_pkg::ROW_OUTPUTS; k++) begin
            base = k * pool_pkg::POOL_STRIDE;
            window_max[k] = row_i[base];
            for (int j = 1; j < pool_pkg::POOL_WINDOW; j++) begin
                pick = (base + j < link_pkg::ROW_PIXELS) ? base + j : link_pkg::ROW_PIXELS - 1;
                if (row_i[pick] > window_max[k]) begin
                    window_max[k] = row_i[pick];
                end
            end
        end
    end

    // New row fits when empty or when the held result leaves now
    assign take_row = row_valid_i && (state == pool_pkg::POOL_EMPTY || !pooled_stall_i);

    always_ff @(posedge clock) begin
        if (reset_i) begin
            state <= pool_pkg::POOL_EMPTY;
        end else if (take_row) begin
            state <= pool_pkg::POOL_FULL;
        end else if (!pooled_stall_i) begin
            state <= pool_pkg::POOL_EMPTY;
        end
    end

    always_ff @(posedge clock) begin
        if (take_row) begin
            pooled_o <= window_max;
        end
    end

    assign pooled_valid_o = (state == pool_pkg::POOL_FULL);
    assign row_stall_o = (state == pool_pkg::POOL_FULL) && pooled_stall_i;

endmodule

/* design/score_serializer.sv */
// Pooled result serializer
`timescale 1ns/10ps

module score_serializer (
    input  logic                              clock,
    input  logic                              reset_i,
    input  logic [link_pkg::VALUE_BITS-1:0]   pooled_i [link_pkg::ROW_OUTPUTS],
    input  logic                              pooled_valid_i,
    input  logic                              word_stall_i,
    output logic                              pooled_stall_o,
    output logic [link_pkg::WORD_BITS-1:0]    word_o,
    output logic                              word_valid_o
);

    link_pkg::stream_state_e state;
    logic [link_pkg::OUTPUT_IDX_BITS-1:0] out_idx;
    logic [link_pkg::VALUE_BITS-1:0] value_buf [link_pkg::ROW_OUTPUTS];

    always_ff @(posedge clock) begin
        if (reset_i) begin
            state <= link_pkg::STREAM_FILL;
            out_idx <= '0;
        end else if (state == link_pkg::STREAM_FILL) begin
            if (pooled_valid_i) begin
                state <= link_pkg::STREAM_HOLD;
            end
        end else if (!word_stall_i) begin
            if (out_idx == link_pkg::LAST_OUTPUT) begin
                // Tenth word taken
                out_idx <= '0;
                state <= link_pkg::STREAM_FILL;
            end else begin
                out_idx <= out_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == link_pkg::STREAM_FILL && pooled_valid_i) begin
            value_buf <= pooled_i;
        end
    end

    assign pooled_stall_o = (state == link_pkg::STREAM_HOLD);
    assign word_valid_o = (state == link_pkg::STREAM_HOLD);

    // One value per word with the upper bits zero
    assign word_o = {{(link_pkg::WORD_BITS - link_pkg::VALUE_BITS){1'b0}}, value_buf[out_idx]};

endmodule

/* design/skid_register.sv */
// Output word register
`timescale 1ns/10ps

module skid_register (
    input  logic                              clock,
    input  logic                              reset_i,
    input  logic [link_pkg::WORD_BITS-1:0]    word_i,
    input  logic                              word_valid_i,
    input  logic                              downstream_stall_i,
    output logic                              word_stall_o,
    output logic [link_pkg::WORD_BITS-1:0]    word_o,
    output logic                              word_valid_o
);

    logic load;

    // Load when empty or when the current word leaves
    assign load = !word_valid_o || !downstream_stall_i;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            word_valid_o <= 1'b0;
        end else if (load) begin
            word_valid_o <= word_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            word_o <= word_i;
        end
    end

    assign word_stall_o = word_valid_o && downstream_stall_i;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module tb_host_adapter -f tb.f -o tb_host_adapter \
    && ./obj_dir/tb_host_adapter > sim.log 2>&1
grep -q "Finished with no errors" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb.f */
design/link_pkg.sv
design/pool_pkg.sv
design/row_gather.sv
design/row_maxpool.sv
design/score_serializer.sv
design/skid_register.sv
design/host_adapter_top.sv
verification/tb_host_adapter.sv

/* verification/adapter_vectors.txt */
# R: 28 pixel values in hex, then the 10 expected pooled values in hex on the next line
# S n: soft reset word sent after n partial pixels of value ff
R 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b
  03 06 09 0c 0f 12 15 18 1b 1b
R ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0 ef ee ed ec eb ea e9 e8 e7 e6 e5 e4
  ff fc f9 f6 f3 f0 ed ea e7 e4
R 00 00 00 50 00 00 00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 00 00 00 00 90 00 05
  50 50 00 80 80 00 00 00 90 05
S 11
R 12 34 56 78 9a bc de f0 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4 c3 d2 e1 f0 01 02 03 04
  78 de f0 4b 78 a5 d2 f0 04 04
R aa 01 02 03 04 c0 05 06 07 08 09 0a 0b 0c e5 0d 0e 0f 10 11 12 13 14 15 16 17 18 19
  aa c0 08 0b e5 10 13 16 19 19
S 27
R 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ff
  00 00 00 00 00 00 00 00 ff ff
R ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0 ef ee ed ec eb ea e9 e8 e7 e6 e5 e4
  ff fc f9 f6 f3 f0 ed ea e7 e4
R 12 34 56 78 9a bc de f0 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4 c3 d2 e1 f0 01 02 03 04
  78 de f0 4b 78 a5 d2 f0 04 04
R 00 00 00 50 00 00 00 00 00 00 00 00 80 00 00 00 00 00 00 00 00 00 00 00 00 90 00 05
  50 50 00 80 80 00 00 00 90 05
R aa 01 02 03 04 c0 05 06 07 08 09 0a 0b 0c e5 0d 0e 0f 10 11 12 13 14 15 16 17 18 19
  aa c0 08 0b e5 10 13 16 19 19
R 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b
  03 06 09 0c 0f 12 15 18 1b 1b

/* verification/tb_host_adapter.sv */
// Host adapter testbench
`timescale 1ns/10ps

module tb_host_adapter;

    localparam string VECTOR_FILE = "verification/adapter_vectors.txt";
    localparam int PLAIN_RECORDS = 3;
    localparam logic [link_pkg::WORD_BITS-1:0] SOFT_RESET_WORD = 1 << link_pkg::SOFT_RESET_BIT;

    logic clock;
    logic reset_i;
    logic [link_pkg::WORD_BITS-1:0] data_i;
    logic valid_i;
    logic downstream_stall_i;
    logic [link_pkg::WORD_BITS-1:0] data_o;
    logic valid_o;
    logic upstream_stall_o;

    // Records as read from the vector file
    bit rec_is_row [$];
    int rec_count [$];
    logic [link_pkg::VALUE_BITS-1:0] pix_store [$];
    logic [link_pkg::VALUE_BITS-1:0] exp_store [$];
    logic [link_pkg::VALUE_BITS-1:0] expect_q [$];

    int seed = 93054;
    int rand_word;
    logic [7:0] gap_roll;
    logic [1:0] stall_left;
    logic random_on;
    int cycle_count;
    int cycle_limit;
    int word_count;

    host_adapter_top i_dut (
        .clock              (clock),
        .reset_i            (reset_i),
        .data_i             (data_i),
        .valid_i            (valid_i),
        .downstream_stall_i (downstream_stall_i),
        .data_o             (data_o),
        .valid_o            (valid_o),
        .upstream_stall_o   (upstream_stall_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [link_pkg::VALUE_BITS-1:0] actual,
                               input logic [link_pkg::VALUE_BITS-1:0] expected,
                               input int index);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %0t: output word %0d carries %h, expected %h",
                               $time, index, actual, expected));
        end
    endtask

    task automatic check_upper_zero(input logic [link_pkg::WORD_BITS-1:0] actual,
                                    input int index);
        if (actual[link_pkg::WORD_BITS-1:link_pkg::VALUE_BITS] !== '0) begin
            fail_run($sformatf("[ERROR] %0t: output word %0d is %h, upper bits not zero",
                               $time, index, actual));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %0t: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic read_vectors();
        int fd;
        int code;
        int count;
        int value;
        int i;
        string tok;
        string rest;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the vector file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "R") begin
                for (i = 0; i < link_pkg::ROW_PIXELS + link_pkg::ROW_OUTPUTS; i++) begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        fail_run("The vector file ends inside a row record");
                    end
                    if (i < link_pkg::ROW_PIXELS) begin
                        pix_store.push_back(value[link_pkg::VALUE_BITS-1:0]);
                    end else begin
                        exp_store.push_back(value[link_pkg::VALUE_BITS-1:0]);
                    end
                end
                rec_is_row.push_back(1'b1);
                rec_count.push_back(link_pkg::ROW_PIXELS);
            end else if (tok == "S") begin
                code = $fscanf(fd, "%d", count);
                if (code != 1) begin
                    fail_run("A soft reset record has no pixel count");
                end
                rec_is_row.push_back(1'b0);
                rec_count.push_back(count);
            end else begin
                fail_run($sformatf("Unknown record type %s in the vector file", tok));
            end
        end
        $fclose(fd);
    endtask

    // Pixel in bits 7..0 with filler above that the adapter ignores
    function automatic logic [link_pkg::WORD_BITS-1:0] pixel_word(
        input logic [link_pkg::VALUE_BITS-1:0] px);
        return {1'b0, 7'h2a, px, px, px};
    endfunction

    // Starts just after a rising edge and returns just after the accepting edge
    task automatic send_word(input logic [link_pkg::WORD_BITS-1:0] value_word);
        logic taken;
        taken = 1'b0;
        data_i <= value_word;
        valid_i <= 1'b1;
        while (!taken) begin
            @(negedge clock);
            taken = !upstream_stall_o || value_word[link_pkg::SOFT_RESET_BIT];
            @(posedge clock);
        end
    endtask

    task automatic insert_gap();
        if (random_on && gap_roll[7:6] == 2'b00) begin
            valid_i <= 1'b0;
            repeat (int'(gap_roll[1:0]) + 1) @(posedge clock);
        end
    endtask

    task automatic wait_drain();
        valid_i <= 1'b0;
        while (expect_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    // Gap rolls and downstream stall bursts
    always @(posedge clock) begin
        rand_word = $random(seed);
        gap_roll <= rand_word[7:0];
        if (!random_on) begin
            stall_left <= '0;
            downstream_stall_i <= 1'b0;
        end else if (stall_left != 2'd0) begin
            stall_left <= stall_left - 1'b1;
            downstream_stall_i <= 1'b1;
        end else if (rand_word[11:9] == 3'd0) begin
            stall_left <= rand_word[13:12];
            downstream_stall_i <= 1'b1;
        end else begin
            downstream_stall_i <= 1'b0;
        end
    end

    // Output monitor samples each word before the edge that takes it
    always @(negedge clock) begin
        if (!reset_i && valid_o === 1'b1 && !downstream_stall_i) begin
            if (expect_q.size() == 0) begin
                fail_run($sformatf("[ERROR] %0t: output word %h arrived with no row pending",
                                   $time, data_o));
            end else begin
                check_upper_zero(data_o, word_count);
                check_value(data_o[link_pkg::VALUE_BITS-1:0], expect_q.pop_front(), word_count);
                word_count = word_count + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("Timeout: the test did not end within %0d clock cycles",
                               cycle_limit));
        end
    end

    initial begin
        int r;
        int i;
        int prd;
        int erd;
        reset_i = 1'b1;
        data_i = '0;
        valid_i = 1'b0;
        downstream_stall_i = 1'b0;
        random_on = 1'b0;
        gap_roll = '0;
        stall_left = '0;
        cycle_count = 0;
        word_count = 0;
        prd = 0;
        erd = 0;
        read_vectors();
        cycle_limit = rec_is_row.size() * (link_pkg::ROW_PIXELS + link_pkg::ROW_OUTPUTS) * 4
                      + 200;

        repeat (16) @(posedge clock);
        reset_i <= 1'b0;
        // Outputs stay quiet until the first pixel
        repeat (4) begin
            @(negedge clock);
            check_flag(valid_o, 1'b0, "valid_o after reset");
            check_flag(upstream_stall_o, 1'b0, "upstream_stall_o after reset");
        end
        @(posedge clock);

        for (r = 0; r < rec_is_row.size(); r++) begin
            // First rows back to back and random timing after them
            if (r == PLAIN_RECORDS) begin
                random_on <= 1'b1;
            end
            if (rec_is_row[r]) begin
                for (i = 0; i < link_pkg::ROW_OUTPUTS; i++) begin
                    expect_q.push_back(exp_store[erd + i]);
                end
                erd = erd + link_pkg::ROW_OUTPUTS;
                for (i = 0; i < link_pkg::ROW_PIXELS; i++) begin
                    insert_gap();
                    send_word(pixel_word(pix_store[prd + i]));
                end
                prd = prd + link_pkg::ROW_PIXELS;
            end else begin
                // Partial row of bright pixels that the soft reset discards
                wait_drain();
                for (i = 0; i < rec_count[r]; i++) begin
                    send_word(pixel_word(8'hff));
                end
                send_word(SOFT_RESET_WORD);
            end
        end

        wait_drain();
        repeat (40) @(posedge clock);
        // Adapter idle again once the last row has left
        @(negedge clock);
        check_flag(valid_o, 1'b0, "valid_o at the end of the run");
        check_flag(upstream_stall_o, 1'b0, "upstream_stall_o at the end of the run");
        $display("Finished with no errors");
        $finish;
    end

endmodule
